// ==== filelist.f ====
source/pipe_pkg.sv
source/fetch_unit.sv
source/stage_register.sv
source/flow_controller.sv
source/retire_unit.sv
source/pipe_core.sv
testbench/pipe_core_assert.sv
testbench/pipe_core_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module pipe_core_tb \
    -f filelist.f -o pipe_core_sim &&
./obj_dir/pipe_core_sim ||
exit 1

// ==== testbench/pipe_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_core_tb;

    localparam int addr_width  = 12;
    localparam int prog_words  = 64;
    localparam int num_retires = 500;
    localparam int timeout_ns  = num_retires * 20 * 100;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic [addr_width-1:0] instruction_addr;
    logic [31:0]           instruction_data;
    logic                  instruction_memory_busy = 1'b0;
    logic                  execute_busy = 1'b0;
    logic                  data_memory_busy = 1'b0;
    logic                  retire_valid;
    logic [addr_width-1:0] retire_pc;
    pipe_pkg::opcode_t     retire_opcode;
    logic [4:0]            retire_dest;
    logic [31:0]           retire_count;

    logic [31:0]           program_mem [prog_words];
    integer                seed = 14;
    int                    retired = 0;
    logic [addr_width-1:0] model_pc = '0;
    logic [31:0]           model_word;
    logic [31:0]           r;

    pipe_core #(.addr_width(addr_width)) u_pipe_core (
        .clk                     (clk),
        .rst                     (rst),
        .instruction_addr        (instruction_addr),
        .instruction_data        (instruction_data),
        .instruction_memory_busy (instruction_memory_busy),
        .execute_busy            (execute_busy),
        .data_memory_busy        (data_memory_busy),
        .retire_valid            (retire_valid),
        .retire_pc               (retire_pc),
        .retire_opcode           (retire_opcode),
        .retire_dest             (retire_dest),
        .retire_count            (retire_count)
    );

    always #50 clk = ~clk;

    // words past the end of the program read as nop
    assign instruction_data = (instruction_addr[addr_width-1:6] == '0) ?
                              program_mem[instruction_addr[5:0]] : 32'h0;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random program, registers 0..3 only so hazards are frequent
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_program();
        logic [31:0]       w;
        pipe_pkg::opcode_t op;
        logic [4:0]        src_a;
        logic              taken;
        logic              prev_load;
        logic [4:0]        prev_dest;
        prev_load = 1'b0;
        prev_dest = '0;
        for (int i = 0; i < prog_words; i++) begin
            w = $random(seed);
            taken = 1'b0;
            src_a = {3'b0, w[7:6]};
            case (w[2:0])
                3'd0: begin
                    op = w[3] ? pipe_pkg::op_jump : pipe_pkg::op_branch;
                    taken = 1'b1;
                end
                3'd1: op = pipe_pkg::op_nop;
                3'd2, 3'd3: op = pipe_pkg::op_alu;
                3'd4, 3'd5: op = pipe_pkg::op_load;
                3'd6: op = pipe_pkg::op_store;
                default: op = pipe_pkg::op_branch;
            endcase
            // consumer straight behind a load
            if (prev_load && w[10]) begin
                src_a = prev_dest;
            end
            // last word jumps back so the model never runs off the end
            if (i == prog_words - 1) begin
                op = pipe_pkg::op_jump;
            end
            program_mem[i] = {op, 3'b0, w[5:4], src_a, 3'b0, w[9:8], taken, 6'b0, w[17:12]};
            prev_load = (op == pipe_pkg::op_load);
            prev_dest = {3'b0, w[5:4]};
        end
    endtask

    // architectural next pc
    function automatic logic [addr_width-1:0] step_pc(input logic [addr_width-1:0] pc,
                                                      input logic [31:0] word);
        pipe_pkg::opcode_t op;
        logic [addr_width-1:0] next;
        op = pipe_pkg::opcode_t'(word[31:28]);
        if (op == pipe_pkg::op_jump || (op == pipe_pkg::op_branch && word[12])) begin
            next = word[addr_width-1:0];
        end else begin
            next = pc + addr_width'(1);
        end
        return next;
    endfunction

    initial begin
        build_program();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            r = $random(seed);
            instruction_memory_busy = (r[3:0] < 4'd3);
            execute_busy = (r[7:4] < 4'd3);
            data_memory_busy = (r[11:8] < 4'd3);
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            // nops never retire
            while (program_mem[model_pc[5:0]][31:28] == 4'd0) begin
                model_pc = step_pc(model_pc, program_mem[model_pc[5:0]]);
            end
            model_word = program_mem[model_pc[5:0]];
            check_value("retire_count", retire_count, 32'(retired));
            check_value("retire_pc", 32'(retire_pc), 32'(model_pc));
            check_value("retire_opcode", 32'(retire_opcode), 32'(model_word[31:28]));
            check_value("retire_dest", 32'(retire_dest), 32'(model_word[27:23]));
            model_pc = step_pc(model_pc, model_word);
            retired++;
            if (retired == num_retires) begin
                $display("No errors");
                $finish;
            end
        end
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the pipeline stopped retiring instructions after %0d", retired);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== testbench/pipe_core_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_core_assert #(
    parameter int addr_width = 12
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [addr_width-1:0] instruction_addr,
    input  logic                  execute_busy,
    input  logic                  data_memory_busy,
    input  logic                  retire_valid
);

    // every stage holds a nop right after a reset edge
    a_quiet_after_reset: assert property (@(posedge clk) rst |=> !retire_valid)
        else $error("retire_valid high in the cycle after reset");

    // a frozen pipeline keeps the pc where it is
    a_pc_held: assert property (@(posedge clk) disable iff (rst)
        (execute_busy || data_memory_busy) |=> $stable(instruction_addr))
        else $error("instruction_addr moved during a frozen cycle");

    a_no_retire_frozen: assert property (@(posedge clk) disable iff (rst)
        (execute_busy || data_memory_busy) |-> !retire_valid)
        else $error("retire_valid high during a frozen cycle");

endmodule

bind pipe_core pipe_core_assert #(.addr_width(addr_width)) u_pipe_core_assert (
    .clk              (clk),
    .rst              (rst),
    .instruction_addr (instruction_addr),
    .execute_busy     (execute_busy),
    .data_memory_busy (data_memory_busy),
    .retire_valid     (retire_valid)
);

`default_nettype wire

// ==== source/pipe_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipe_core #(
    parameter int addr_width = 12
) (
    input  logic                               clk,
    input  logic                               rst,
    output logic [addr_width-1:0]              instruction_addr,
    input  logic [pipe_pkg::instr_width-1:0]   instruction_data,
    input  logic                               instruction_memory_busy,
    input  logic                               execute_busy,
    input  logic                               data_memory_busy,
    output logic                               retire_valid,
    output logic [addr_width-1:0]              retire_pc,
    output pipe_pkg::opcode_t                  retire_opcode,
    output logic [pipe_pkg::reg_width-1:0]     retire_dest,
    output logic [31:0]                        retire_count
);

    // entry 0 is the fetch output, entry k+1 the output of stage k
    pipe_pkg::opcode_t                pipe_opcode [pipe_pkg::num_stages+1];
    logic [pipe_pkg::reg_width-1:0]   pipe_dest   [pipe_pkg::num_stages+1];
    logic [pipe_pkg::reg_width-1:0]   pipe_src_a  [pipe_pkg::num_stages+1];
    logic [pipe_pkg::reg_width-1:0]   pipe_src_b  [pipe_pkg::num_stages+1];
    logic                             pipe_taken  [pipe_pkg::num_stages+1];
    logic [addr_width-1:0]            pipe_target [pipe_pkg::num_stages+1];
    logic [addr_width-1:0]            pipe_pc     [pipe_pkg::num_stages+1];

    logic [pipe_pkg::num_stages-1:0]  stall;
    logic [pipe_pkg::num_stages-1:0]  nullify;
    logic                             redirect;
    logic [addr_width-1:0]            redirect_pc;
    logic                             stall_fetch;

    fetch_unit #(.addr_width(addr_width)) u_fetch_unit (
        .clk                     (clk),
        .rst                     (rst),
        .stall_fetch             (stall_fetch),
        .redirect                (redirect),
        .redirect_pc             (redirect_pc),
        .instruction_addr        (instruction_addr),
        .instruction_data        (instruction_data),
        .instruction_memory_busy (instruction_memory_busy),
        .fetch_opcode            (pipe_opcode[0]),
        .fetch_dest              (pipe_dest[0]),
        .fetch_src_a             (pipe_src_a[0]),
        .fetch_src_b             (pipe_src_b[0]),
        .fetch_taken             (pipe_taken[0]),
        .fetch_target            (pipe_target[0]),
        .fetch_pc                (pipe_pc[0])
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode, execute, memory, write-back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar k = 0; k < pipe_pkg::num_stages; k++) begin : g_stage
        stage_register #(.addr_width(addr_width)) u_stage_register (
            .clk        (clk),
            .rst        (rst),
            .stall      (stall[k]),
            .nullify    (nullify[k]),
            .in_opcode  (pipe_opcode[k]),
            .in_dest    (pipe_dest[k]),
            .in_src_a   (pipe_src_a[k]),
            .in_src_b   (pipe_src_b[k]),
            .in_taken   (pipe_taken[k]),
            .in_target  (pipe_target[k]),
            .in_pc      (pipe_pc[k]),
            .out_opcode (pipe_opcode[k+1]),
            .out_dest   (pipe_dest[k+1]),
            .out_src_a  (pipe_src_a[k+1]),
            .out_src_b  (pipe_src_b[k+1]),
            .out_taken  (pipe_taken[k+1]),
            .out_target (pipe_target[k+1]),
            .out_pc     (pipe_pc[k+1])
        );
    end

    flow_controller #(.addr_width(addr_width)) u_flow_controller (
        .decode_opcode           (pipe_opcode[1]),
        .decode_src_a            (pipe_src_a[1]),
        .decode_src_b            (pipe_src_b[1]),
        .decode_target           (pipe_target[1]),
        .execute_opcode          (pipe_opcode[2]),
        .execute_dest            (pipe_dest[2]),
        .execute_taken           (pipe_taken[2]),
        .execute_target          (pipe_target[2]),
        .execute_busy            (execute_busy),
        .data_memory_busy        (data_memory_busy),
        .instruction_memory_busy (instruction_memory_busy),
        .stall                   (stall),
        .nullify                 (nullify),
        .redirect                (redirect),
        .redirect_pc             (redirect_pc),
        .stall_fetch             (stall_fetch)
    );

    retire_unit #(.addr_width(addr_width)) u_retire_unit (
        .clk           (clk),
        .rst           (rst),
        .wb_opcode     (pipe_opcode[pipe_pkg::num_stages]),
        .wb_dest       (pipe_dest[pipe_pkg::num_stages]),
        .wb_pc         (pipe_pc[pipe_pkg::num_stages]),
        .frozen        (stall[pipe_pkg::num_stages-1]),
        .retire_valid  (retire_valid),
        .retire_pc     (retire_pc),
        .retire_opcode (retire_opcode),
        .retire_dest   (retire_dest),
        .retire_count  (retire_count)
    );

endmodule

`default_nettype wire

// ==== source/retire_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module retire_unit #(
    parameter int addr_width = 12
) (
    input  logic                               clk,
    input  logic                               rst,
    input  pipe_pkg::opcode_t                  wb_opcode,
    input  logic [pipe_pkg::reg_width-1:0]     wb_dest,
    input  logic [addr_width-1:0]              wb_pc,
    input  logic                               frozen,
    output logic                               retire_valid,
    output logic [addr_width-1:0]              retire_pc,
    output pipe_pkg::opcode_t                  retire_opcode,
    output logic [pipe_pkg::reg_width-1:0]     retire_dest,
    output logic [31:0]                        retire_count
);

    // a record sits in write-back for exactly one unfrozen cycle
    assign retire_valid  = (wb_opcode != pipe_pkg::op_nop) && !frozen;
    assign retire_pc     = wb_pc;
    assign retire_opcode = wb_opcode;
    assign retire_dest   = wb_dest;

    // retirements before the one currently shown
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_count <= '0;
        end else if (retire_valid) begin
            retire_count <= retire_count + 32'd1;
        end
    end

endmodule

`default_nettype wire

// ==== source/flow_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module flow_controller #(
    parameter int addr_width = 12
) (
    input  pipe_pkg::opcode_t                  decode_opcode,
    input  logic [pipe_pkg::reg_width-1:0]     decode_src_a,
    input  logic [pipe_pkg::reg_width-1:0]     decode_src_b,
    input  logic [addr_width-1:0]              decode_target,
    input  pipe_pkg::opcode_t                  execute_opcode,
    input  logic [pipe_pkg::reg_width-1:0]     execute_dest,
    input  logic                               execute_taken,
    input  logic [addr_width-1:0]              execute_target,
    input  logic                               execute_busy,
    input  logic                               data_memory_busy,
    input  logic                               instruction_memory_busy,
    output logic [pipe_pkg::num_stages-1:0]    stall,
    output logic [pipe_pkg::num_stages-1:0]    nullify,
    output logic                               redirect,
    output logic [addr_width-1:0]              redirect_pc,
    output logic                               stall_fetch
);

    localparam int st_decode  = 0;
    localparam int st_execute = 1;

    logic load_use;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // operand use per opcode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic reads_src_a(input pipe_pkg::opcode_t op);
        return op inside {pipe_pkg::op_alu, pipe_pkg::op_load,
                          pipe_pkg::op_store, pipe_pkg::op_branch};
    endfunction

    function automatic logic reads_src_b(input pipe_pkg::opcode_t op);
        return op inside {pipe_pkg::op_alu, pipe_pkg::op_store, pipe_pkg::op_branch};
    endfunction

    // load result is not ready until memory
    // r0 never carries a dependency
    assign load_use = (execute_opcode == pipe_pkg::op_load)
                   && (execute_dest != '0)
                   && ((reads_src_a(decode_opcode) && (decode_src_a == execute_dest))
                    || (reads_src_b(decode_opcode) && (decode_src_b == execute_dest)));

    // later rules override earlier ones
    always_comb begin
        redirect    = 1'b0;
        redirect_pc = '0;
        stall_fetch = 1'b0;
        stall       = '0;
        nullify     = '0;

        // jump resolves in decode
        if (decode_opcode == pipe_pkg::op_jump) begin
            redirect             = 1'b1;
            redirect_pc          = decode_target;
            nullify[st_decode]   = 1'b1;
        end

        // taken branch is older, so it wins over a jump behind it
        if ((execute_opcode == pipe_pkg::op_branch) && execute_taken) begin
            redirect             = 1'b1;
            redirect_pc          = execute_target;
            nullify[st_decode]   = 1'b1;
            nullify[st_execute]  = 1'b1;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stalls
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        if (instruction_memory_busy) begin
            // the busy word is dropped anyway, so a redirect may still move the pc
            stall_fetch          = !redirect;
            nullify[st_decode]   = 1'b1;
        end

        // bubble into execute while the consumer waits in decode
        if (load_use) begin
            stall_fetch          = 1'b1;
            stall[st_decode]     = 1'b1;
            nullify[st_execute]  = 1'b1;
        end

        // freeze everything
        // the redirect comes back next cycle
        if (execute_busy || data_memory_busy) begin
            stall_fetch = 1'b1;
            stall       = '1;
            nullify     = '0;
            redirect    = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== source/stage_register.sv ====
`timescale 1ns/1ns
`default_nettype none

module stage_register #(
    parameter int addr_width = 12
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               stall,
    input  logic                               nullify,
    input  pipe_pkg::opcode_t                  in_opcode,
    input  logic [pipe_pkg::reg_width-1:0]     in_dest,
    input  logic [pipe_pkg::reg_width-1:0]     in_src_a,
    input  logic [pipe_pkg::reg_width-1:0]     in_src_b,
    input  logic                               in_taken,
    input  logic [addr_width-1:0]              in_target,
    input  logic [addr_width-1:0]              in_pc,
    output pipe_pkg::opcode_t                  out_opcode,
    output logic [pipe_pkg::reg_width-1:0]     out_dest,
    output logic [pipe_pkg::reg_width-1:0]     out_src_a,
    output logic [pipe_pkg::reg_width-1:0]     out_src_b,
    output logic                               out_taken,
    output logic [addr_width-1:0]              out_target,
    output logic [addr_width-1:0]              out_pc
);

    // stall keeps the record even when nullify is also set
    always_ff @(posedge clk) begin
        if (rst) begin
            out_opcode <= pipe_pkg::op_nop;
        end else if (!stall) begin
            out_opcode <= nullify ? pipe_pkg::op_nop : in_opcode;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (nullify) begin
                out_dest  <= '0;
                out_src_a <= '0;
                out_src_b <= '0;
                out_taken <= 1'b0;
            end else begin
                out_dest  <= in_dest;
                out_src_a <= in_src_a;
                out_src_b <= in_src_b;
                out_taken <= in_taken;
            end
            out_target <= in_target;
            out_pc     <= in_pc;
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
    parameter int addr_width = 12
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               stall_fetch,
    input  logic                               redirect,
    input  logic [addr_width-1:0]              redirect_pc,
    output logic [addr_width-1:0]              instruction_addr,
    input  logic [pipe_pkg::instr_width-1:0]   instruction_data,
    input  logic                               instruction_memory_busy,
    output pipe_pkg::opcode_t                  fetch_opcode,
    output logic [pipe_pkg::reg_width-1:0]     fetch_dest,
    output logic [pipe_pkg::reg_width-1:0]     fetch_src_a,
    output logic [pipe_pkg::reg_width-1:0]     fetch_src_b,
    output logic                               fetch_taken,
    output logic [addr_width-1:0]              fetch_target,
    output logic [addr_width-1:0]              fetch_pc
);

    logic [addr_width-1:0]             pc;
    logic [pipe_pkg::target_width-1:0] target_field;

    assign instruction_addr = pc;
    assign fetch_pc         = pc;
    assign target_field     = instruction_data[pipe_pkg::target_lsb +: pipe_pkg::target_width];

    // a busy memory hands decode a bubble
    always_comb begin
        if (instruction_memory_busy) begin
            fetch_opcode = pipe_pkg::op_nop;
            fetch_dest   = '0;
            fetch_src_a  = '0;
            fetch_src_b  = '0;
            fetch_taken  = 1'b0;
            fetch_target = '0;
        end else begin
            fetch_opcode = pipe_pkg::opcode_t'(
                instruction_data[pipe_pkg::opcode_lsb +: pipe_pkg::opcode_width]);
            fetch_dest   = instruction_data[pipe_pkg::dest_lsb +: pipe_pkg::reg_width];
            fetch_src_a  = instruction_data[pipe_pkg::src_a_lsb +: pipe_pkg::reg_width];
            fetch_src_b  = instruction_data[pipe_pkg::src_b_lsb +: pipe_pkg::reg_width];
            fetch_taken  = instruction_data[pipe_pkg::taken_pos];
            // narrow pc spaces only keep the low target bits
            fetch_target = target_field[addr_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!stall_fetch) begin
            if (redirect) begin
                pc <= redirect_pc;
            end else begin
                pc <= pc + addr_width'(1);
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int instr_width  = 32;
    localparam int opcode_width = 4;
    localparam int reg_width    = 5;
    localparam int target_width = 12;

    // decode, execute, memory, write-back
    localparam int num_stages = 4;

    // bit positions, packed from the top of the word down
    localparam int opcode_lsb = instr_width - opcode_width;
    localparam int dest_lsb   = opcode_lsb - reg_width;
    localparam int src_a_lsb  = dest_lsb - reg_width;
    localparam int src_b_lsb  = src_a_lsb - reg_width;
    localparam int taken_pos  = src_b_lsb - 1;
    localparam int target_lsb = taken_pos - target_width;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // micro-op kinds
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [opcode_width-1:0] {
        op_nop    = 4'd0,
        op_alu    = 4'd1,
        op_load   = 4'd2,
        op_store  = 4'd3,
        op_branch = 4'd4,
        op_jump   = 4'd5
    } opcode_t;

endpackage

`default_nettype wire
